/* src/periph_settings.svh */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// apb bus widths
`define PERIPH_ADDR_W       16
`define PERIPH_DATA_W       32

// peripheral select field in paddr
`define PERIPH_SEL_HI       13
`define PERIPH_SEL_LO       12
`define PERIPH_SEL_SPI      2'd0
`define PERIPH_SEL_UART     2'd1
`define PERIPH_SEL_GPIO     2'd2
`define PERIPH_OFS_W        8

// gpio pads plus the two sampled interrupt lines
`define GPIO_W              6
`define GPIO_IRQ_UART_BIT   6
`define GPIO_IRQ_SPI_BIT    7

// 0 flash, 1 sd card
`define SPI_CS_NUM          2

`define SPI_CTRL            8'h00
`define SPI_TXDATA          8'h04
`define SPI_RXDATA          8'h08
`define SPI_STATUS          8'h0C

`define UART_DIV            8'h00
`define UART_TXDATA         8'h04
`define UART_STATUS         8'h08
`define UART_DIV_RESET      16'd16

`define GPIO_OUT            8'h00
`define GPIO_OE             8'h04
`define GPIO_IN             8'h08
`define GPIO_IRQ_EN         8'h0C
`define GPIO_IRQ_PEND       8'h10

`endif

/* src/periph_pkg.sv */
`include "periph_settings.svh"

package periph_pkg;

  typedef logic [`PERIPH_ADDR_W-1:0] paddr_t;
  typedef logic [`PERIPH_DATA_W-1:0] pdata_t;

  typedef logic [7:0] byte_t;

  typedef logic [`GPIO_W-1:0] gpio_pad_t;
  // pads plus uart and spi interrupt bits
  typedef logic [`GPIO_IRQ_SPI_BIT:0] gpio_in_t;

  // active low chip selects
  typedef logic [`SPI_CS_NUM-1:0] spi_cs_t;
  // spi half period is div + 1 cycles
  typedef logic [7:0] spi_div_t;
  // uart cycles per bit
  typedef logic [15:0] uart_div_t;

  typedef struct packed {
    logic   psel;
    logic   penable;
    logic   pwrite;
    paddr_t paddr;
    pdata_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic   pready;
    pdata_t prdata;
    logic   pslverr;
  } apb_rsp_t;

  typedef enum logic {
    SPI_IDLE,
    SPI_SHIFT
  } spi_state_e;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

endpackage

/* src/apb_demux.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module apb_demux (
  input  logic                 clk,
  input  logic                 rst_n,
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  output periph_pkg::apb_req_t spi_req_o,
  output periph_pkg::apb_req_t uart_req_o,
  output periph_pkg::apb_req_t gpio_req_o,
  input  periph_pkg::apb_rsp_t spi_rsp_i,
  input  periph_pkg::apb_rsp_t uart_rsp_i,
  input  periph_pkg::apb_rsp_t gpio_rsp_i
);

  logic [1:0]         sel;
  logic               unmapped;
  logic               err_q;
  periph_pkg::paddr_t ofs_addr;

  assign sel      = req_i.paddr[`PERIPH_SEL_HI:`PERIPH_SEL_LO];
  assign unmapped = (sel != `PERIPH_SEL_SPI) && (sel != `PERIPH_SEL_UART) &&
                    (sel != `PERIPH_SEL_GPIO);
  // slaves only see their register offset
  assign ofs_addr = periph_pkg::paddr_t'(req_i.paddr[`PERIPH_OFS_W-1:0]);

  always_comb begin
    spi_req_o        = req_i;
    spi_req_o.psel   = req_i.psel && (sel == `PERIPH_SEL_SPI);
    spi_req_o.paddr  = ofs_addr;
    uart_req_o       = req_i;
    uart_req_o.psel  = req_i.psel && (sel == `PERIPH_SEL_UART);
    uart_req_o.paddr = ofs_addr;
    gpio_req_o       = req_i;
    gpio_req_o.psel  = req_i.psel && (sel == `PERIPH_SEL_GPIO);
    gpio_req_o.paddr = ofs_addr;
  end

  // set in the setup phase, so it is high for exactly the access phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= req_i.psel && !req_i.penable && unmapped;
    end
  end

  always_comb begin
    case (sel)
      `PERIPH_SEL_SPI:  rsp_o = spi_rsp_i;
      `PERIPH_SEL_UART: rsp_o = uart_rsp_i;
      `PERIPH_SEL_GPIO: rsp_o = gpio_rsp_i;
      default: begin
        rsp_o.pready  = err_q;
        rsp_o.prdata  = '0;
        rsp_o.pslverr = err_q;
      end
    endcase
  end

endmodule

/* src/spi_master.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module spi_master (
  input  logic                 clk,
  input  logic                 rst_n,
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  output logic                 spi_clk_o,
  output periph_pkg::spi_cs_t  spi_cs_o,
  output logic                 spi_mosi_o,
  input  logic                 spi_miso_i,
  output logic                 irq_o
);

  periph_pkg::spi_state_e   state_q;
  periph_pkg::spi_div_t     div_q;
  periph_pkg::spi_div_t     cnt_q;
  periph_pkg::byte_t        tx_q;
  periph_pkg::byte_t        rx_q;
  logic                     dev_q;
  logic                     irq_en_q;
  logic                     cs_force_q;
  logic                     sclk_q;
  logic                     done_q;
  logic [3:0]               half_q;
  logic [`PERIPH_OFS_W-1:0] ofs;
  logic                     access;
  logic                     wr_en;
  logic                     busy;
  logic                     tx_wr;
  logic                     ofs_ok;
  logic                     half_end;

  assign ofs      = req_i.paddr[`PERIPH_OFS_W-1:0];
  assign access   = req_i.psel && req_i.penable;
  assign wr_en    = access && req_i.pwrite;
  assign tx_wr    = wr_en && (ofs == `SPI_TXDATA);
  assign busy     = (state_q == periph_pkg::SPI_SHIFT);
  assign half_end = busy && (cnt_q == div_q);

  always_comb begin
    case (ofs)
      `SPI_CTRL, `SPI_TXDATA, `SPI_RXDATA, `SPI_STATUS: ofs_ok = 1'b1;
      default: ofs_ok = 1'b0;
    endcase
  end

  always_comb begin
    case (ofs)
      `SPI_CTRL:   rsp_o.prdata = periph_pkg::pdata_t'({div_q, 5'b0, cs_force_q,
                                                        irq_en_q, dev_q});
      `SPI_TXDATA: rsp_o.prdata = periph_pkg::pdata_t'(tx_q);
      `SPI_RXDATA: rsp_o.prdata = periph_pkg::pdata_t'(rx_q);
      `SPI_STATUS: rsp_o.prdata = periph_pkg::pdata_t'({done_q, busy});
      default:     rsp_o.prdata = '0;
    endcase
  end

  assign rsp_o.pready  = access;
  assign rsp_o.pslverr = access && (!ofs_ok || (tx_wr && busy));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dev_q      <= 1'b0;
      irq_en_q   <= 1'b0;
      cs_force_q <= 1'b0;
      div_q      <= '0;
    end else if (wr_en && (ofs == `SPI_CTRL)) begin
      dev_q      <= req_i.pwdata[0];
      irq_en_q   <= req_i.pwdata[1];
      cs_force_q <= req_i.pwdata[2];
      div_q      <= req_i.pwdata[15:8];
    end
  end

  // 16 half periods of div + 1 cycles each
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= periph_pkg::SPI_IDLE;
      cnt_q   <= '0;
      half_q  <= '0;
      sclk_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (wr_en && (ofs == `SPI_STATUS) && req_i.pwdata[1]) begin
        done_q <= 1'b0;
      end
      case (state_q)
        periph_pkg::SPI_IDLE: begin
          if (tx_wr) begin
            state_q <= periph_pkg::SPI_SHIFT;
            cnt_q   <= '0;
            half_q  <= '0;
          end
        end
        periph_pkg::SPI_SHIFT: begin
          if (half_end) begin
            cnt_q  <= '0;
            sclk_q <= ~sclk_q;
            half_q <= half_q + 4'd1;
            if (half_q == 4'd15) begin
              state_q <= periph_pkg::SPI_IDLE;
              done_q  <= 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 8'd1;
          end
        end
      endcase
    end
  end

  // mode 0 samples on rising sclk and shifts out on falling
  always_ff @(posedge clk) begin
    if (!busy && tx_wr) begin
      tx_q <= req_i.pwdata[7:0];
    end else if (half_end && sclk_q) begin
      tx_q <= {tx_q[6:0], 1'b0};
    end
    if (half_end && !sclk_q) begin
      rx_q <= {rx_q[6:0], spi_miso_i};
    end
  end

  always_comb begin
    spi_cs_o = '1;
    if (busy || cs_force_q) begin
      spi_cs_o[dev_q] = 1'b0;
    end
  end

  assign spi_clk_o  = sclk_q;
  assign spi_mosi_o = busy && tx_q[7];
  assign irq_o      = done_q && irq_en_q;

endmodule

/* src/uart_tx.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module uart_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  periph_pkg::apb_req_t req_i,
  output periph_pkg::apb_rsp_t rsp_o,
  output logic                 uart_tx_o,
  output logic                 irq_o
);

  periph_pkg::uart_state_e  state_q;
  periph_pkg::uart_div_t    div_q;
  periph_pkg::uart_div_t    cnt_q;
  periph_pkg::byte_t        sh_q;
  logic [2:0]               bit_q;
  logic                     done_q;
  logic [`PERIPH_OFS_W-1:0] ofs;
  logic                     access;
  logic                     wr_en;
  logic                     busy;
  logic                     tx_wr;
  logic                     ofs_ok;
  logic                     bit_end;

  assign ofs     = req_i.paddr[`PERIPH_OFS_W-1:0];
  assign access  = req_i.psel && req_i.penable;
  assign wr_en   = access && req_i.pwrite;
  assign tx_wr   = wr_en && (ofs == `UART_TXDATA);
  assign busy    = (state_q != periph_pkg::UART_IDLE);
  assign bit_end = (cnt_q == div_q - 16'd1);
  assign ofs_ok  = (ofs == `UART_DIV) || (ofs == `UART_TXDATA) || (ofs == `UART_STATUS);

  always_comb begin
    case (ofs)
      `UART_DIV:    rsp_o.prdata = periph_pkg::pdata_t'(div_q);
      `UART_STATUS: rsp_o.prdata = periph_pkg::pdata_t'({done_q, busy});
      default:      rsp_o.prdata = '0;
    endcase
  end

  assign rsp_o.pready  = access;
  assign rsp_o.pslverr = access && (!ofs_ok || (tx_wr && busy));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_q <= `UART_DIV_RESET;
    end else if (wr_en && (ofs == `UART_DIV)) begin
      div_q <= req_i.pwdata[15:0];
    end
  end

  // start, 8 data bits, stop; each div cycles
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= periph_pkg::UART_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      if (wr_en && (ofs == `UART_STATUS) && req_i.pwdata[1]) begin
        done_q <= 1'b0;
      end
      if (busy) begin
        cnt_q <= bit_end ? '0 : cnt_q + 16'd1;
      end
      case (state_q)
        periph_pkg::UART_IDLE: begin
          if (tx_wr) begin
            state_q <= periph_pkg::UART_START;
            cnt_q   <= '0;
          end
        end
        periph_pkg::UART_START: begin
          if (bit_end) begin
            state_q <= periph_pkg::UART_DATA;
          end
        end
        periph_pkg::UART_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 3'd1;
            if (bit_q == 3'd7) begin
              state_q <= periph_pkg::UART_STOP;
            end
          end
        end
        periph_pkg::UART_STOP: begin
          if (bit_end) begin
            state_q <= periph_pkg::UART_IDLE;
            done_q  <= 1'b1;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (!busy && tx_wr) begin
      sh_q <= req_i.pwdata[7:0];
    end else if ((state_q == periph_pkg::UART_DATA) && bit_end) begin
      sh_q <= {1'b0, sh_q[7:1]};
    end
  end

  always_comb begin
    case (state_q)
      periph_pkg::UART_START: uart_tx_o = 1'b0;
      periph_pkg::UART_DATA:  uart_tx_o = sh_q[0];
      default:                uart_tx_o = 1'b1;
    endcase
  end

  assign irq_o = done_q;

endmodule

/* src/gpio_ctrl.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module gpio_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  periph_pkg::apb_req_t  req_i,
  output periph_pkg::apb_rsp_t  rsp_o,
  input  periph_pkg::gpio_pad_t gpio_i,
  input  logic                  uart_irq_i,
  input  logic                  spi_irq_i,
  output periph_pkg::gpio_pad_t gpio_o,
  output periph_pkg::gpio_pad_t gpio_oe_o,
  output logic                  irq_o
);

  periph_pkg::gpio_pad_t    out_q;
  periph_pkg::gpio_pad_t    oe_q;
  periph_pkg::gpio_in_t     in_raw;
  periph_pkg::gpio_in_t     sync1_q;
  periph_pkg::gpio_in_t     sync2_q;
  periph_pkg::gpio_in_t     in_q;
  periph_pkg::gpio_in_t     irq_en_q;
  periph_pkg::gpio_in_t     pend_q;
  periph_pkg::gpio_in_t     pend_clr;
  logic [`PERIPH_OFS_W-1:0] ofs;
  logic                     access;
  logic                     wr_en;
  logic                     ofs_ok;

  assign ofs    = req_i.paddr[`PERIPH_OFS_W-1:0];
  assign access = req_i.psel && req_i.penable;
  assign wr_en  = access && req_i.pwrite;

  always_comb begin
    in_raw                     = '0;
    in_raw[`GPIO_W-1:0]        = gpio_i;
    in_raw[`GPIO_IRQ_UART_BIT] = uart_irq_i;
    in_raw[`GPIO_IRQ_SPI_BIT]  = spi_irq_i;
  end

  always_comb begin
    ofs_ok = 1'b1;
    case (ofs)
      `GPIO_OUT:      rsp_o.prdata = periph_pkg::pdata_t'(out_q);
      `GPIO_OE:       rsp_o.prdata = periph_pkg::pdata_t'(oe_q);
      `GPIO_IN:       rsp_o.prdata = periph_pkg::pdata_t'(in_q);
      `GPIO_IRQ_EN:   rsp_o.prdata = periph_pkg::pdata_t'(irq_en_q);
      `GPIO_IRQ_PEND: rsp_o.prdata = periph_pkg::pdata_t'(pend_q);
      default: begin
        rsp_o.prdata = '0;
        ofs_ok       = 1'b0;
      end
    endcase
  end

  assign rsp_o.pready  = access;
  assign rsp_o.pslverr = access && !ofs_ok;

  // write 1 to clear
  assign pend_clr = (wr_en && (ofs == `GPIO_IRQ_PEND)) ?
                    req_i.pwdata[`GPIO_IRQ_SPI_BIT:0] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
      sync1_q  <= '0;
      sync2_q  <= '0;
      in_q     <= '0;
      pend_q   <= '0;
    end else begin
      if (wr_en && (ofs == `GPIO_OUT)) begin
        out_q <= req_i.pwdata[`GPIO_W-1:0];
      end
      if (wr_en && (ofs == `GPIO_OE)) begin
        oe_q <= req_i.pwdata[`GPIO_W-1:0];
      end
      if (wr_en && (ofs == `GPIO_IRQ_EN)) begin
        irq_en_q <= req_i.pwdata[`GPIO_IRQ_SPI_BIT:0];
      end
      sync1_q <= in_raw;
      sync2_q <= sync1_q;
      in_q    <= sync2_q;
      // a new edge wins over a clear in the same cycle
      pend_q  <= (pend_q & ~pend_clr) | (sync2_q & ~in_q & irq_en_q);
    end
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign irq_o     = |pend_q;

endmodule

/* src/periph_top.sv */
`timescale 1ns/1ps

module periph_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  periph_pkg::apb_req_t  apb_req_i,
  output periph_pkg::apb_rsp_t  apb_rsp_o,
  output logic                  spi_clk_o,
  output periph_pkg::spi_cs_t   spi_cs_o,
  output logic                  spi_mosi_o,
  input  logic                  spi_miso_i,
  output logic                  uart_tx_o,
  input  periph_pkg::gpio_pad_t gpio_i,
  output periph_pkg::gpio_pad_t gpio_o,
  output periph_pkg::gpio_pad_t gpio_oe_o,
  output logic                  irq_o
);

  periph_pkg::apb_req_t spi_req;
  periph_pkg::apb_req_t uart_req;
  periph_pkg::apb_req_t gpio_req;
  periph_pkg::apb_rsp_t spi_rsp;
  periph_pkg::apb_rsp_t uart_rsp;
  periph_pkg::apb_rsp_t gpio_rsp;
  logic                 spi_irq;
  logic                 uart_irq;

  apb_demux u_apb_demux (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (apb_req_i),
    .rsp_o      (apb_rsp_o),
    .spi_req_o  (spi_req),
    .uart_req_o (uart_req),
    .gpio_req_o (gpio_req),
    .spi_rsp_i  (spi_rsp),
    .uart_rsp_i (uart_rsp),
    .gpio_rsp_i (gpio_rsp)
  );

  // cs 0 flash, cs 1 sd card
  spi_master u_spi_master (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (spi_req),
    .rsp_o      (spi_rsp),
    .spi_clk_o  (spi_clk_o),
    .spi_cs_o   (spi_cs_o),
    .spi_mosi_o (spi_mosi_o),
    .spi_miso_i (spi_miso_i),
    .irq_o      (spi_irq)
  );

  uart_tx u_uart_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (uart_req),
    .rsp_o     (uart_rsp),
    .uart_tx_o (uart_tx_o),
    .irq_o     (uart_irq)
  );

  // peripheral interrupts reach the core through gpio
  gpio_ctrl u_gpio_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (gpio_req),
    .rsp_o      (gpio_rsp),
    .gpio_i     (gpio_i),
    .uart_irq_i (uart_irq),
    .spi_irq_i  (spi_irq),
    .gpio_o     (gpio_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (irq_o)
  );

endmodule

/* verif/periph_asserts.sv */
`timescale 1ns/1ps

module periph_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input periph_pkg::apb_req_t req_i,
  input periph_pkg::apb_rsp_t rsp_i,
  input periph_pkg::spi_cs_t  spi_cs_i,
  input logic                 uart_tx_i,
  input logic                 uart_busy_i
);

  // read by the testbench summary
  int fail_cnt = 0;

  // every slave answers in the access phase
  assert property (@(posedge clk) disable iff (!rst_n)
                   (req_i.psel && req_i.penable) |-> rsp_i.pready)
    else begin
      fail_cnt++;
      $error("pready low in an access phase");
    end

  assert property (@(posedge clk) disable iff (!rst_n) $countones(~spi_cs_i) <= 1)
    else begin
      fail_cnt++;
      $error("more than one spi chip select low");
    end

  // line idles high between frames
  assert property (@(posedge clk) disable iff (!rst_n) !uart_busy_i |-> uart_tx_i)
    else begin
      fail_cnt++;
      $error("uart_tx_o low while uart idle");
    end

endmodule

bind periph_top periph_asserts u_periph_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .req_i       (apb_req_i),
  .rsp_i       (apb_rsp_o),
  .spi_cs_i    (spi_cs_o),
  .uart_tx_i   (uart_tx_o),
  .uart_busy_i (u_uart_tx.busy)
);

/* verif/periph_tb.sv */
`timescale 1ns/1ps
`include "periph_settings.svh"

module periph_tb;

  localparam int CLK_PERIOD  = 100;
  localparam int DRIVE_DLY   = 10;
  localparam int SPI_WORST   = 16 * 256;
  localparam int UART_DIV_TB = 8;
  localparam int SPI_BYTES   = 3;
  localparam int UART_FRAMES = 2;
  // register accesses, polls and idle gaps over all tests
  localparam int REG_CYCLES  = 600;
  localparam int WDOG_CYCLES = (SPI_BYTES * SPI_WORST + UART_FRAMES * 10 * UART_DIV_TB +
                                REG_CYCLES) * 12 / 10;

  logic                  clk;
  logic                  rst_n;
  periph_pkg::apb_req_t  apb_req;
  periph_pkg::apb_rsp_t  apb_rsp;
  logic                  spi_clk;
  periph_pkg::spi_cs_t   spi_cs;
  logic                  spi_mosi;
  logic                  uart_tx;
  periph_pkg::gpio_pad_t gpio_in;
  periph_pkg::gpio_pad_t gpio_out;
  periph_pkg::gpio_pad_t gpio_oe;
  logic                  irq;

  integer seed = 32'h4159_4958;
  int     err_cnt;
  int     check_cnt;
  int     test_cnt;
  int     test_fail_cnt;
  int     total_err;
  logic   cs_watch;
  logic   cs_dev;
  logic   cs_sel_seen;
  logic   cs_other_seen;
  logic   sclk_prev;
  int     sclk_rises;

  // register values the tests expect to survive later accesses
  periph_pkg::pdata_t exp_gpio_out;
  periph_pkg::pdata_t exp_gpio_oe;
  periph_pkg::pdata_t exp_spi_ctrl;
  periph_pkg::pdata_t exp_uart_div;

  // miso looped back from mosi
  periph_top DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .spi_clk_o  (spi_clk),
    .spi_cs_o   (spi_cs),
    .spi_mosi_o (spi_mosi),
    .spi_miso_i (spi_mosi),
    .uart_tx_o  (uart_tx),
    .gpio_i     (gpio_in),
    .gpio_o     (gpio_out),
    .gpio_oe_o  (gpio_oe),
    .irq_o      (irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // chip select and spi clock activity during an spi transfer
  always @(negedge clk) begin
    if (cs_watch) begin
      if (spi_cs[cs_dev] == 1'b0) begin
        cs_sel_seen = 1'b1;
      end
      if (spi_cs[!cs_dev] == 1'b0) begin
        cs_other_seen = 1'b1;
      end
      if (spi_clk && !sclk_prev) begin
        sclk_rises++;
      end
    end
    sclk_prev = spi_clk;
  end

  task automatic step(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DLY);
  endtask

  function automatic periph_pkg::paddr_t reg_addr(input logic [1:0] sel, input logic [7:0] ofs);
    periph_pkg::paddr_t a;
    a = '0;
    a[`PERIPH_SEL_HI:`PERIPH_SEL_LO] = sel;
    a[`PERIPH_OFS_W-1:0] = ofs;
    return a;
  endfunction

  task automatic report_fail(input string msg);
    err_cnt++;
    $display("error: %s at %0t", msg, $time);
  endtask

  task automatic check_pdata(input string name, input periph_pkg::pdata_t exp,
                             input periph_pkg::pdata_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s exp 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  task automatic check_byte(input string name, input periph_pkg::byte_t exp,
                            input periph_pkg::byte_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s exp 0x%02h got 0x%02h", name, exp, got);
    end
  endtask

  task automatic check_pad(input string name, input periph_pkg::gpio_pad_t exp,
                           input periph_pkg::gpio_pad_t got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s exp 0x%02h got 0x%02h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s exp 0x%0h got 0x%0h", name, exp, got);
    end
  endtask

  // entered and left a drive delay after a rising edge; setup then access
  task automatic apb_xfer(input logic wr, input periph_pkg::paddr_t addr,
                          input periph_pkg::pdata_t wdata, output periph_pkg::pdata_t rdata,
                          output logic slverr);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    step(1);
    apb_req.penable = 1'b1;
    @(negedge clk);
    if (apb_rsp.pready !== 1'b1) begin
      report_fail($sformatf("pready not high in access phase of 0x%04h", addr));
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    step(1);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input periph_pkg::paddr_t addr, input periph_pkg::pdata_t data,
                           output logic slverr);
    periph_pkg::pdata_t unused;
    apb_xfer(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input periph_pkg::paddr_t addr, output periph_pkg::pdata_t data,
                          output logic slverr);
    apb_xfer(1'b0, addr, '0, data, slverr);
  endtask

  task automatic write_ok(input periph_pkg::paddr_t addr, input periph_pkg::pdata_t data);
    logic err;
    apb_write(addr, data, err);
    check_bit("pslverr", 1'b0, err);
  endtask

  task automatic read_ok(input periph_pkg::paddr_t addr, output periph_pkg::pdata_t data);
    logic err;
    apb_read(addr, data, err);
    check_bit("pslverr", 1'b0, err);
  endtask

  task automatic wait_idle(input periph_pkg::paddr_t status_addr, input int max_polls,
                           input string name, output periph_pkg::pdata_t status);
    int n;
    n = 0;
    read_ok(status_addr, status);
    while (status[0] && n < max_polls) begin
      read_ok(status_addr, status);
      n++;
    end
    if (status[0] !== 1'b0) begin
      report_fail($sformatf("%s busy did not clear after %0d polls", name, max_polls));
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("%-16s PASS", name);
    end else begin
      test_fail_cnt++;
      $display("%-16s FAIL (%0d errors)", name, err_cnt - err_before);
    end
  endtask

  task automatic test_reset_gpio();
    int                    e;
    int                    n;
    periph_pkg::gpio_pad_t in_val;
    periph_pkg::pdata_t    rd;
    e = err_cnt;
    check_bit("spi_cs_o[0]", 1'b1, spi_cs[0]);
    check_bit("spi_cs_o[1]", 1'b1, spi_cs[1]);
    check_bit("spi_clk_o", 1'b0, spi_clk);
    check_bit("spi_mosi_o", 1'b0, spi_mosi);
    check_bit("uart_tx_o", 1'b1, uart_tx);
    check_pad("gpio_o", '0, gpio_out);
    check_pad("gpio_oe_o", '0, gpio_oe);
    check_bit("irq_o", 1'b0, irq);
    check_bit("pready", 1'b0, apb_rsp.pready);
    check_bit("pslverr", 1'b0, apb_rsp.pslverr);
    exp_gpio_out = periph_pkg::pdata_t'(periph_pkg::gpio_pad_t'($random(seed)));
    exp_gpio_oe  = periph_pkg::pdata_t'(periph_pkg::gpio_pad_t'($random(seed)));
    write_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OUT), exp_gpio_out);
    write_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OE), exp_gpio_oe);
    check_pad("gpio_o", periph_pkg::gpio_pad_t'(exp_gpio_out), gpio_out);
    check_pad("gpio_oe_o", periph_pkg::gpio_pad_t'(exp_gpio_oe), gpio_oe);
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OUT), rd);
    check_pdata("GPIO_OUT", exp_gpio_out, rd);
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OE), rd);
    check_pdata("GPIO_OE", exp_gpio_oe, rd);
    // nonzero so the synchronizer has something to pass
    in_val  = ~periph_pkg::gpio_pad_t'(exp_gpio_out) | 6'h01;
    gpio_in = in_val;
    n = 0;
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IN), rd);
    while (rd !== periph_pkg::pdata_t'(in_val) && n < 8) begin
      read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IN), rd);
      n++;
    end
    check_pdata("GPIO_IN", periph_pkg::pdata_t'(in_val), rd);
    end_test("reset_gpio", e);
  endtask

  task automatic test_spi_loopback();
    int                   e;
    int                   d;
    logic                 err;
    periph_pkg::spi_div_t div;
    periph_pkg::byte_t    tx;
    periph_pkg::pdata_t   rd;
    e = err_cnt;
    for (d = 0; d < 2; d++) begin
      div          = (d == 0) ? 8'd1 : 8'd3;
      exp_spi_ctrl = periph_pkg::pdata_t'({div, 7'b0, d[0]});
      write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_CTRL), exp_spi_ctrl);
      tx            = periph_pkg::byte_t'($random(seed));
      cs_dev        = d[0];
      cs_sel_seen   = 1'b0;
      cs_other_seen = 1'b0;
      sclk_rises    = 0;
      cs_watch      = 1'b1;
      write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_TXDATA), periph_pkg::pdata_t'(tx));
      // second byte lands while the first is still shifting
      apb_write(reg_addr(`PERIPH_SEL_SPI, `SPI_TXDATA), periph_pkg::pdata_t'(~tx), err);
      check_bit("pslverr", 1'b1, err);
      wait_idle(reg_addr(`PERIPH_SEL_SPI, `SPI_STATUS), SPI_WORST / 2 + 4, "spi", rd);
      cs_watch = 1'b0;
      check_pdata("SPI_STATUS", 32'h2, rd);
      check_bit("spi_cs_o selected", 1'b1, cs_sel_seen);
      check_bit("spi_cs_o other", 1'b0, cs_other_seen);
      // one rising spi clock per bit, idle low afterwards
      check_pdata("spi_clk_o rises", 32'd8, periph_pkg::pdata_t'(sclk_rises));
      check_bit("spi_clk_o", 1'b0, spi_clk);
      read_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_RXDATA), rd);
      check_byte("SPI_RXDATA", tx, periph_pkg::byte_t'(rd));
      write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_STATUS), 32'h2);
    end
    end_test("spi_loopback", e);
  endtask

  task automatic test_uart_frame();
    int                 e;
    int                 i;
    periph_pkg::byte_t  tx;
    periph_pkg::byte_t  rx;
    periph_pkg::pdata_t rd;
    e = err_cnt;
    exp_uart_div = periph_pkg::pdata_t'(UART_DIV_TB);
    write_ok(reg_addr(`PERIPH_SEL_UART, `UART_DIV), exp_uart_div);
    tx = periph_pkg::byte_t'($random(seed));
    write_ok(reg_addr(`PERIPH_SEL_UART, `UART_TXDATA), periph_pkg::pdata_t'(tx));
    // start bit began on the completing edge; move to its midpoint
    step(UART_DIV_TB / 2);
    check_bit("uart_tx_o start", 1'b0, uart_tx);
    for (i = 0; i < 8; i++) begin
      step(UART_DIV_TB);
      rx[i] = uart_tx;
    end
    check_byte("uart_tx_o data", tx, rx);
    step(UART_DIV_TB);
    check_bit("uart_tx_o stop", 1'b1, uart_tx);
    wait_idle(reg_addr(`PERIPH_SEL_UART, `UART_STATUS), 10 * UART_DIV_TB, "uart", rd);
    check_pdata("UART_STATUS", 32'h2, rd);
    write_ok(reg_addr(`PERIPH_SEL_UART, `UART_STATUS), 32'h2);
    end_test("uart_frame", e);
  endtask

  task automatic test_irq_routing();
    int                 e;
    int                 n;
    periph_pkg::pdata_t rd;
    e = err_cnt;
    write_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_EN), 32'hC0);
    write_ok(reg_addr(`PERIPH_SEL_UART, `UART_TXDATA), periph_pkg::pdata_t'($random(seed) & 8'hFF));
    wait_idle(reg_addr(`PERIPH_SEL_UART, `UART_STATUS), 10 * UART_DIV_TB, "uart", rd);
    // divisor 0, interrupt enable, flash select
    exp_spi_ctrl = 32'h2;
    write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_CTRL), exp_spi_ctrl);
    write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_TXDATA), periph_pkg::pdata_t'($random(seed) & 8'hFF));
    wait_idle(reg_addr(`PERIPH_SEL_SPI, `SPI_STATUS), SPI_WORST / 2 + 4, "spi", rd);
    n = 0;
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_PEND), rd);
    while (rd !== 32'hC0 && n < 8) begin
      read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_PEND), rd);
      n++;
    end
    check_pdata("GPIO_IRQ_PEND", 32'hC0, rd);
    check_bit("irq_o", 1'b1, irq);
    write_ok(reg_addr(`PERIPH_SEL_UART, `UART_STATUS), 32'h2);
    write_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_STATUS), 32'h2);
    write_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_PEND), 32'hC0);
    check_bit("irq_o", 1'b0, irq);
    // falling interrupt levels must not set pending again
    step(4);
    check_bit("irq_o", 1'b0, irq);
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_PEND), rd);
    check_pdata("GPIO_IRQ_PEND", 32'h0, rd);
    write_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_IRQ_EN), 32'h0);
    end_test("irq_routing", e);
  endtask

  task automatic test_bad_address();
    int                 e;
    logic               err;
    periph_pkg::pdata_t rd;
    e = err_cnt;
    apb_write(reg_addr(2'd3, 8'h00), 32'hDEAD_BEEF, err);
    check_bit("pslverr", 1'b1, err);
    apb_read(reg_addr(2'd3, 8'h04), rd, err);
    check_bit("pslverr", 1'b1, err);
    check_pdata("prdata", 32'h0, rd);
    apb_write(reg_addr(`PERIPH_SEL_SPI, 8'h10), 32'hFFFF_FFFF, err);
    check_bit("pslverr", 1'b1, err);
    apb_read(reg_addr(`PERIPH_SEL_SPI, 8'h10), rd, err);
    check_bit("pslverr", 1'b1, err);
    read_ok(reg_addr(`PERIPH_SEL_SPI, `SPI_CTRL), rd);
    check_pdata("SPI_CTRL", exp_spi_ctrl, rd);
    read_ok(reg_addr(`PERIPH_SEL_UART, `UART_DIV), rd);
    check_pdata("UART_DIV", exp_uart_div, rd);
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OUT), rd);
    check_pdata("GPIO_OUT", exp_gpio_out, rd);
    read_ok(reg_addr(`PERIPH_SEL_GPIO, `GPIO_OE), rd);
    check_pdata("GPIO_OE", exp_gpio_oe, rd);
    end_test("bad_address", e);
  endtask

  initial begin
    rst_n         = 1'b0;
    apb_req       = '0;
    gpio_in       = '0;
    cs_watch      = 1'b0;
    cs_dev        = 1'b0;
    cs_sel_seen   = 1'b0;
    cs_other_seen = 1'b0;
    sclk_prev     = 1'b0;
    sclk_rises    = 0;
    err_cnt       = 0;
    check_cnt     = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    repeat (5) @(posedge clk);
    #(DRIVE_DLY);
    rst_n = 1'b1;
    test_reset_gpio();
    test_spi_loopback();
    test_uart_frame();
    test_irq_routing();
    test_bad_address();
    total_err = err_cnt + DUT.u_periph_asserts.fail_cnt;
    $display("summary: %0d run, %0d failing, %0d checks, %0d errors, %0d assertion errors",
             test_cnt, test_fail_cnt, check_cnt, err_cnt, DUT.u_periph_asserts.fail_cnt);
    if (total_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* periph.f */
+incdir+src
src/periph_pkg.sv
src/apb_demux.sv
src/spi_master.sv
src/uart_tx.sv
src/gpio_ctrl.sv
src/periph_top.sv
verif/periph_asserts.sv
verif/periph_tb.sv

/* Bender.yml */
package:
  name: periph

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/periph_pkg.sv
      - src/apb_demux.sv
      - src/spi_master.sv
      - src/uart_tx.sv
      - src/gpio_ctrl.sv
      - src/periph_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/periph_asserts.sv
      - verif/periph_tb.sv
